/* bench/spi_master_props.sv */
`timescale 1ns/1ps

module spi_master_props #(
    parameter int CPOL = 0
) (
    input logic rst,
    input logic clk,
    input logic ss_n,
    input logic sclk,
    input logic ready,
    input logic done
);

    localparam logic SCLK_IDLE = (CPOL != 0);

    int fail_count = 0;    // Read by the testbench at the end of the run

    // Serial clock parked while deselected
    sclk_idle_a: assert property (@(posedge rst) disable iff (clk) ss_n |-> (sclk == SCLK_IDLE))
        else begin
            fail_count++;
            $error("sclk left its idle level while ss_n was high");
        end

    no_ready_in_frame_a: assert property (@(posedge rst) disable iff (clk) !ss_n |-> !ready)
        else begin
            fail_count++;
            $error("ready was high during a frame");
        end

    done_ready_a: assert property (@(posedge rst) disable iff (clk) done |-> ready)
        else begin
            fail_count++;    // Frame end must free the host side
            $error("done pulsed while ready was low");
        end

endmodule

bind spi_master spi_master_props #(.CPOL(CPOL)) u_props (
    .rst(rst), .clk(clk), .ss_n(ss_n), .sclk(sclk), .ready(ready), .done(done)
);

/* bench/tb_spi_master.sv */
`timescale 1ns/1ps

module tb_spi_master;

    localparam int CLKS_PER_HALF_SCLK = 2;
    localparam int CPOL = 0;
    localparam int CPHA = 0;
    localparam logic SCLK_IDLE = (CPOL != 0);
    localparam int ACCEPT_TIMEOUT = 20;     // Cycles
    localparam int FRAME_TIMEOUT  = 400;    // Longest frame is about 260 cycles
    localparam int B2B_FRAMES     = 30;
    localparam logic [31:0] SEED  = 32'hd9cf693a;

    logic              rst;    // Clock
    logic              clk;    // Reset, active high
    spi_pkg::spi_req_t req;
    logic              valid;
    logic              ready;
    spi_pkg::data_t    data_out;
    logic              done;
    logic              sclk;
    logic              ss_n;
    logic              mosi;
    logic              miso = 1'b0;

    logic [31:0]       lfsr;
    int                error_count;
    int                check_count;
    int                accept_count = 0;

    // Slave model state, frame info set by the host side at acceptance
    int                slave_tx_len = 0;
    int                slave_rx_len = 0;
    spi_pkg::data_t    slave_word = '0;
    logic              sclk_q = SCLK_IDLE;
    logic              ss_n_q = 1'b1;
    logic [63:0]       mosi_seen = '0;
    int                cap_seen = 0;
    int                launch_seen = 0;
    int                frame_count = 0;

    spi_master #(
        .CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK),
        .CPOL(CPOL),
        .CPHA(CPHA)
    ) UUT (
        .rst(rst), .clk(clk), .req(req), .valid(valid), .ready(ready),
        .data_out(data_out), .done(done), .sclk(sclk), .ss_n(ss_n),
        .mosi(mosi), .miso(miso)
    );

    initial begin
        rst = 1'b0;
        forever #50 rst = ~rst;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);    // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic random_request(input int kind, output spi_pkg::spi_req_t r,
                                  output spi_pkg::data_t word);
        logic [31:0] v;
        logic [2:0]  t;
        take_bits(3, v);
        t = (kind < 0) ? 3'(v % 6) : 3'(kind);
        r.cmd_type = spi_pkg::cmd_type_e'(t);
        take_bits(8, v);
        r.command = v[7:0];
        take_bits(24, v);
        r.address = v[23:0];
        take_bits(32, v);
        r.wdata = v;
        take_bits(5, v);
        r.nbits = 7'(v[4:0]) + 7'd1;    // 1 to 32
        take_bits(32, word);
    endtask

    // Reference model, mosi string right-aligned with the first bit on top
    task automatic expected_frame(input spi_pkg::spi_req_t r, input spi_pkg::data_t word,
                                  output logic [63:0] bits, output int tx_len,
                                  output int rx_len, output spi_pkg::data_t rd);
        logic [63:0] mask;
        int          n;
        n      = int'(r.nbits);
        mask   = (64'd1 << n) - 64'd1;
        bits   = 64'(r.command);
        tx_len = 8;
        rx_len = 0;
        rd     = '0;
        if (r.cmd_type inside {spi_pkg::CMD_ADDR_READ, spi_pkg::CMD_ADDR_WRITE, spi_pkg::CMD_ADDR}) begin
            bits   = (bits << 24) | 64'(r.address);
            tx_len = tx_len + 24;
        end
        if (r.cmd_type inside {spi_pkg::CMD_WRITE, spi_pkg::CMD_ADDR_WRITE}) begin
            bits   = (bits << n) | (64'(r.wdata) & mask);
            tx_len = tx_len + n;
        end
        if (r.cmd_type inside {spi_pkg::CMD_READ, spi_pkg::CMD_ADDR_READ}) begin
            bits   = bits << n;    // mosi low while reading
            rx_len = n;
            rd     = slave_word_mask(word, mask);
        end
    endtask

    function automatic spi_pkg::data_t slave_word_mask(input spi_pkg::data_t w,
                                                       input logic [63:0] mask);
        return w & mask[31:0];
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        error_count++;
        $display("FAILED %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // SPI slave, works on sampled sclk so it sees each edge one cycle late
    always @(posedge rst) begin : slave_model
        logic lead_edge;
        logic trail_edge;
        logic cap_edge;
        logic launch_edge;
        int   k;
        lead_edge   = (sclk != sclk_q) && (sclk != SCLK_IDLE);
        trail_edge  = (sclk != sclk_q) && (sclk == SCLK_IDLE);
        cap_edge    = (CPHA != 0) ? trail_edge : lead_edge;
        launch_edge = (CPHA != 0) ? lead_edge : trail_edge;
        if (clk) begin
            miso <= 1'b0;
        end else if (ss_n_q && !ss_n) begin
            mosi_seen   = '0;
            cap_seen    = 0;
            launch_seen = 0;
            frame_count++;
            miso <= 1'b0;
        end else if (!ss_n) begin
            if (cap_edge) begin
                mosi_seen = {mosi_seen[62:0], mosi};
                cap_seen++;
            end
            if (launch_edge) begin
                k = launch_seen - slave_tx_len + ((CPHA != 0) ? 0 : 1);
                if (k >= 0 && k < slave_rx_len)
                    miso <= slave_word[slave_rx_len - 1 - k];    // MSB of the read field first
                else
                    miso <= 1'b0;
                launch_seen++;
            end
        end
        sclk_q = sclk;
        ss_n_q = ss_n;
    end

    always @(posedge rst) begin
        if (!clk && valid && ready)
            accept_count++;
    end

    task automatic wait_for_accept();
        int cycles;
        cycles = 0;
        while (!(valid && ready)) begin
            if (cycles == ACCEPT_TIMEOUT)
                report_timeout("request was never accepted");
            @(posedge rst);
            cycles++;
        end
    endtask

    task automatic wait_for_frame_end();
        int cycles;
        cycles = 0;
        do begin
            @(posedge rst);
            cycles++;
            if (cycles > FRAME_TIMEOUT)
                report_timeout("ready did not return after a frame");
        end while (!ready);
    endtask

    task automatic check_frame(input spi_pkg::spi_req_t r, input spi_pkg::data_t w);
        logic [63:0]    exp_bits;
        int             tx_len;
        int             rx_len;
        spi_pkg::data_t exp_data;
        expected_frame(r, w, exp_bits, tx_len, rx_len, exp_data);
        check_count++;
        assert (cap_seen == tx_len + rx_len)
            else report_value("sclk cycles", cap_seen, tx_len + rx_len);
        assert (mosi_seen == exp_bits)
            else report_value("mosi", mosi_seen, exp_bits);
        assert (data_out === exp_data)
            else report_value("data_out", data_out, exp_data);
        assert (done === 1'b1)
            else report_value("done", done, 1);
    endtask

    task automatic run_sequence(input int kind, input int count, input bit back_to_back);
        spi_pkg::spi_req_t r;
        spi_pkg::spi_req_t cur_req;
        spi_pkg::data_t    w;
        spi_pkg::data_t    cur_word;
        spi_pkg::data_t    rd;
        logic [63:0]       bits;
        int                i;
        int                acc_before;
        int                frames_before;
        acc_before    = accept_count;
        frames_before = frame_count;
        random_request(kind, r, w);
        req   <= r;
        valid <= 1'b1;
        for (i = 0; i < count; i++) begin
            cur_req  = r;
            cur_word = w;
            wait_for_accept();
            expected_frame(cur_req, cur_word, bits, slave_tx_len, slave_rx_len, rd);
            slave_word = cur_word;
            if (back_to_back && i < count - 1) begin
                random_request(kind, r, w);
                req <= r;    // valid stays high
            end else begin
                valid <= 1'b0;
            end
            wait_for_frame_end();
            check_frame(cur_req, cur_word);
            if (!back_to_back && i < count - 1) begin
                repeat (2) @(posedge rst);
                random_request(kind, r, w);
                req   <= r;
                valid <= 1'b1;
            end
        end
        assert (accept_count - acc_before == count && frame_count - frames_before == count)
            else begin
                error_count++;
                $display("Request count mismatch at %0t ns: %0d accepted, %0d frames, %0d sent",
                         $time, accept_count - acc_before, frame_count - frames_before, count);
            end
    endtask

    task automatic report_test(input int id, input string name, input int errors_before);
        $display("Test %0d %s: %s", id, name,
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        int errs;
        clk         = 1'b1;
        valid       = 1'b0;
        req         = '0;
        lfsr        = SEED;
        error_count = 0;
        check_count = 0;
        repeat (4) @(posedge rst);
        clk <= 1'b0;
        @(posedge rst);

        errs = error_count;
        assert (ready === 1'b1) else report_value("ready", ready, 1);
        assert (ss_n === 1'b1) else report_value("ss_n", ss_n, 1);
        assert (sclk === SCLK_IDLE) else report_value("sclk", sclk, SCLK_IDLE);
        assert (data_out === '0) else report_value("data_out", data_out, 0);
        assert (done === 1'b0 && mosi === 1'b0) else report_value("done,mosi", {done, mosi}, 0);
        report_test(1, "reset state", errs);

        errs = error_count;
        run_sequence(int'(spi_pkg::CMD_ONLY), 3, 1'b0);
        run_sequence(int'(spi_pkg::CMD_ADDR), 3, 1'b0);
        report_test(2, "command and command+address frames", errs);

        errs = error_count;
        run_sequence(int'(spi_pkg::CMD_WRITE), 4, 1'b0);
        run_sequence(int'(spi_pkg::CMD_ADDR_WRITE), 4, 1'b0);
        report_test(3, "write frames", errs);

        errs = error_count;
        run_sequence(int'(spi_pkg::CMD_READ), 4, 1'b0);
        run_sequence(int'(spi_pkg::CMD_ADDR_READ), 4, 1'b0);
        report_test(4, "read frames", errs);

        errs = error_count;
        run_sequence(-1, B2B_FRAMES, 1'b1);
        report_test(5, "back-to-back random requests", errs);

        errs = error_count + UUT.u_props.fail_count;
        $display("Frames checked: %0d, errors: %0d", check_count, errs);
        if (errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* compile.f */
design/spi_pkg.sv
design/spi_sclk_gen.sv
design/spi_shift_engine.sv
design/spi_frame_ctrl.sv
design/spi_master.sv
bench/spi_master_props.sv
bench/tb_spi_master.sv

/* design/spi_frame_ctrl.sv */
`timescale 1ns/1ps

module spi_frame_ctrl (
    input  logic               rst,
    input  logic               clk,
    input  spi_pkg::spi_req_t  req,
    input  logic               valid,
    output logic               ready,
    output spi_pkg::data_t     data_out,
    output logic               done,
    output logic               ss_n,
    output spi_pkg::edge_cnt_t edge_total,
    output logic               sclk_start,
    input  logic               sclk_finished,
    output logic               load,
    output spi_pkg::tx_str_t   tx_str,
    output spi_pkg::nbits_t    tx_bits,
    input  spi_pkg::data_t     rdata
);

    spi_pkg::ctrl_state_e state;
    spi_pkg::spi_req_t    req_q;
    logic                 accept;
    logic                 go;          // Start pulse shared by clock gen and shifter
    spi_pkg::data_t       wdata_al;    // Write bits moved to the top
    spi_pkg::data_t       rd_mask;
    spi_pkg::tx_str_t     tx_str_d;
    spi_pkg::nbits_t      tx_bits_d;
    spi_pkg::nbits_t      rx_bits_d;
    spi_pkg::edge_cnt_t   cycles_d;

    assign accept     = valid && ready;
    assign sclk_start = go;
    assign load       = go;

    assign wdata_al = req_q.wdata << (spi_pkg::DATA_W - int'(req_q.nbits));
    assign rd_mask  = {spi_pkg::DATA_W{1'b1}} >> (spi_pkg::DATA_W - int'(req_q.nbits));

    // Frame layout from the command type
    always_comb begin
        tx_str_d  = {req_q.command, {(spi_pkg::TX_W - spi_pkg::CMD_W){1'b0}}};
        tx_bits_d = spi_pkg::nbits_t'(spi_pkg::CMD_W);
        rx_bits_d = '0;
        case (req_q.cmd_type)
            spi_pkg::CMD_READ: begin
                rx_bits_d = req_q.nbits;
            end
            spi_pkg::CMD_ADDR_READ: begin
                tx_str_d  = {req_q.command, req_q.address, {spi_pkg::DATA_W{1'b0}}};
                tx_bits_d = spi_pkg::nbits_t'(spi_pkg::CMD_W + spi_pkg::ADDR_W);
                rx_bits_d = req_q.nbits;
            end
            spi_pkg::CMD_WRITE: begin
                tx_str_d  = {req_q.command, wdata_al, {spi_pkg::ADDR_W{1'b0}}};
                tx_bits_d = spi_pkg::nbits_t'(spi_pkg::CMD_W) + req_q.nbits;
            end
            spi_pkg::CMD_ADDR_WRITE: begin
                tx_str_d  = {req_q.command, req_q.address, wdata_al};
                tx_bits_d = spi_pkg::nbits_t'(spi_pkg::CMD_W + spi_pkg::ADDR_W) + req_q.nbits;
            end
            spi_pkg::CMD_ADDR: begin
                tx_str_d  = {req_q.command, req_q.address, {spi_pkg::DATA_W{1'b0}}};
                tx_bits_d = spi_pkg::nbits_t'(spi_pkg::CMD_W + spi_pkg::ADDR_W);
            end
            default: ;    // Command only
        endcase
        cycles_d = spi_pkg::edge_cnt_t'(tx_bits_d) + spi_pkg::edge_cnt_t'(rx_bits_d);
    end

    // Request and frame description, stable for the whole frame
    always_ff @(posedge rst) begin
        if (accept) begin
            req_q <= req;
        end
        if (state == spi_pkg::SETUP) begin
            tx_str     <= tx_str_d;
            tx_bits    <= tx_bits_d;
            edge_total <= cycles_d << 1;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= spi_pkg::IDLE;
            ready    <= 1'b1;
            done     <= 1'b0;
            ss_n     <= 1'b1;
            go       <= 1'b0;
            data_out <= '0;
        end else begin
            done <= 1'b0;
            go   <= 1'b0;
            case (state)
                spi_pkg::IDLE: begin
                    if (accept) begin
                        ready <= 1'b0;
                        state <= spi_pkg::SETUP;
                    end
                end
                spi_pkg::SETUP: begin
                    go    <= 1'b1;
                    state <= spi_pkg::TRANSFER;
                end
                spi_pkg::TRANSFER: begin
                    ss_n <= 1'b0;    // Falls together with the first mosi bit
                    if (sclk_finished) begin
                        ss_n     <= 1'b1;
                        ready    <= 1'b1;
                        done     <= 1'b1;
                        data_out <= rdata & rd_mask;
                        state    <= spi_pkg::IDLE;
                    end
                end
                default: begin
                    ss_n  <= 1'b1;
                    ready <= 1'b1;
                    state <= spi_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* design/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
    parameter int CLKS_PER_HALF_SCLK = 2,
    parameter int CPOL               = 0,
    parameter int CPHA               = 0
) (
    input  logic              rst,
    input  logic              clk,
    input  spi_pkg::spi_req_t req,
    input  logic              valid,
    output logic              ready,
    output spi_pkg::data_t    data_out,
    output logic              done,
    output logic              sclk,
    output logic              ss_n,
    output logic              mosi,
    input  logic              miso
);

    spi_pkg::edge_cnt_t edge_total;
    spi_pkg::tx_str_t   tx_str;
    spi_pkg::nbits_t    tx_bits;
    spi_pkg::data_t     rdata;
    logic               sclk_start;
    logic               sclk_finished;
    logic               load;
    logic               lead;
    logic               trail;

    spi_frame_ctrl u_ctrl (
        .rst(rst), .clk(clk),
        .req(req), .valid(valid), .ready(ready),
        .data_out(data_out), .done(done), .ss_n(ss_n),
        .edge_total(edge_total), .sclk_start(sclk_start), .sclk_finished(sclk_finished),
        .load(load), .tx_str(tx_str), .tx_bits(tx_bits), .rdata(rdata)
    );

    spi_sclk_gen #(.CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK), .CPOL(CPOL)) u_sclk (
        .rst(rst), .clk(clk),
        .start(sclk_start), .edge_total(edge_total),
        .lead(lead), .trail(trail), .sclk(sclk), .finished(sclk_finished)
    );

    spi_shift_engine #(.CPHA(CPHA)) u_shift (
        .rst(rst), .clk(clk),
        .load(load), .tx_str(tx_str), .tx_bits(tx_bits),
        .lead(lead), .trail(trail),
        .mosi(mosi), .miso(miso), .rdata(rdata)
    );

endmodule

/* design/spi_pkg.sv */
package spi_pkg;

    // Field widths
    localparam int DATA_W  = 32;
    localparam int CMD_W   = 8;
    localparam int ADDR_W  = 24;
    localparam int NBITS_W = 7;    // Holds up to 64, the longest transmit string
    localparam int EDGE_W  = 9;    // Two edges per serial clock, 64 clocks max
    localparam int TX_W    = CMD_W + ADDR_W + DATA_W;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [CMD_W-1:0]   cmd_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [NBITS_W-1:0] nbits_t;
    typedef logic [EDGE_W-1:0]  edge_cnt_t;
    typedef logic [TX_W-1:0]    tx_str_t;    // Left-aligned, MSB goes out first

    // Frame layouts a host may request
    typedef enum logic [2:0] {
        CMD_ONLY       = 3'd0,
        CMD_READ       = 3'd1,
        CMD_ADDR_READ  = 3'd2,
        CMD_WRITE      = 3'd3,
        CMD_ADDR_WRITE = 3'd4,
        CMD_ADDR       = 3'd5
    } cmd_type_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        SETUP    = 2'd1,
        TRANSFER = 2'd2
    } ctrl_state_e;

    // One host request, held stable by the host until accepted
    typedef struct packed {
        cmd_type_e cmd_type;
        cmd_t      command;
        addr_t     address;
        data_t     wdata;     // Low nbits are sent for write types
        nbits_t    nbits;     // 1 to 32
    } spi_req_t;

endpackage

/* design/spi_sclk_gen.sv */
`timescale 1ns/1ps

module spi_sclk_gen #(
    parameter int CLKS_PER_HALF_SCLK = 2,
    parameter int CPOL               = 0
) (
    input  logic               rst,
    input  logic               clk,
    input  logic               start,
    input  spi_pkg::edge_cnt_t edge_total,
    output logic               lead,
    output logic               trail,
    output logic               sclk,
    output logic               finished
);

    localparam int DIV_W = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_HALF_SCLK - 1);
    localparam logic SCLK_IDLE = (CPOL != 0);

    logic [DIV_W-1:0]   div_cnt;
    spi_pkg::edge_cnt_t edges_left;
    logic               active;
    logic               tick;

    // An edge is due when the half period expires
    assign tick  = active && (div_cnt == DIV_LAST);
    assign lead  = tick && (sclk == SCLK_IDLE);    // Away from idle level
    assign trail = tick && (sclk != SCLK_IDLE);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            div_cnt    <= '0;
            edges_left <= '0;
            active     <= 1'b0;
            sclk       <= SCLK_IDLE;
            finished   <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                active     <= 1'b1;
                div_cnt    <= '0;
                edges_left <= edge_total;
            end else if (tick) begin
                div_cnt    <= '0;
                edges_left <= edges_left - 1'b1;
                if (edges_left == spi_pkg::edge_cnt_t'(1)) begin
                    // Last edge of the frame, park the clock
                    active   <= 1'b0;
                    sclk     <= SCLK_IDLE;
                    finished <= 1'b1;
                end else begin
                    sclk <= ~sclk;
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine #(
    parameter int CPHA = 0
) (
    input  logic             rst,
    input  logic             clk,
    input  logic             load,
    input  spi_pkg::tx_str_t tx_str,
    input  spi_pkg::nbits_t  tx_bits,
    input  logic             lead,
    input  logic             trail,
    output logic             mosi,
    input  logic             miso,
    output spi_pkg::data_t   rdata
);

    localparam logic PHASE = (CPHA != 0);

    spi_pkg::tx_str_t tx_sreg;
    spi_pkg::nbits_t  tx_cnt;     // Bits already placed on mosi
    spi_pkg::nbits_t  cap_cnt;    // Capture edges seen during transmit
    logic             capture;
    logic             launch;

    // Mode 0/2 sample on the leading edge, mode 1/3 on the trailing edge
    assign capture = PHASE ? trail : lead;
    assign launch  = PHASE ? lead : trail;

    // Transmit side
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mosi   <= 1'b0;
            tx_cnt <= '0;
        end else if (load) begin
            // With CPHA 0 the first bit must be set up before the first edge
            mosi   <= PHASE ? 1'b0 : tx_str[spi_pkg::TX_W-1];
            tx_cnt <= PHASE ? spi_pkg::nbits_t'(0) : spi_pkg::nbits_t'(1);
        end else if (launch) begin
            if (tx_cnt < tx_bits) begin
                mosi   <= tx_sreg[spi_pkg::TX_W-1];
                tx_cnt <= tx_cnt + 1'b1;
            end else begin
                mosi <= 1'b0;    // Receive bits
            end
        end
    end

    always_ff @(posedge rst) begin
        if (load) begin
            tx_sreg <= PHASE ? tx_str : tx_str << 1;
        end else if (launch) begin
            tx_sreg <= tx_sreg << 1;
        end
    end

    // Receive side
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cap_cnt <= '0;
        end else if (load) begin
            cap_cnt <= '0;
        end else if (capture && (cap_cnt < tx_bits)) begin
            cap_cnt <= cap_cnt + 1'b1;
        end
    end

    // Only bits after the transmit string enter the read word
    always_ff @(posedge rst) begin
        if (load) begin
            rdata <= '0;
        end else if (capture && (cap_cnt >= tx_bits)) begin
            rdata <= {rdata[spi_pkg::DATA_W-2:0], miso};
        end
    end

endmodule
